//--- verilog/fifo_pkg.sv
// ------------------------------
// Shared sizes and the item struct
// for the flop-based FIFO
// ------------------------------

package fifo_pkg;

  // ------------------------------
  // Storage sizing
  // ------------------------------

  // RAM entries, power of two so addresses wrap on their own
  localparam int FIFO_DEPTH = 4;

  // RAM address width
  localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

  // Item count in the RAM, must reach FIFO_DEPTH itself
  localparam int FIFO_COUNT_W = $clog2(FIFO_DEPTH + 1);

  // Empty FIFO may hand a beat straight to the output stage
  localparam bit FIFO_ENABLE_BYPASS = 1'b1;

  // ------------------------------
  // Item layout
  // ------------------------------

  // Tag field width
  localparam int FIFO_TAG_W = 4;

  // Payload field width
  localparam int FIFO_PAYLOAD_W = 16;

  // One FIFO entry
  // Same type on push port, bypass, RAM and pop port
  typedef struct packed {
    logic [FIFO_TAG_W-1:0]     tag;
    logic [FIFO_PAYLOAD_W-1:0] payload;
  } fifo_item_t;

endpackage

//--- verilog/fifo_push_ctrl_core.sv
// ------------------------------
// Push control core with bypass
// steering and RAM write address
// ------------------------------

`timescale 1ns/1ps

module fifo_push_ctrl_core #(
  parameter bit EnableBypass = 1'b1
) (
  input  logic                            clk,
  input  logic                            rst_n,

  // Push port
  input  logic                            push_valid,
  input  fifo_pkg::fifo_item_t            push_item,
  output logic                            push_ready,

  // Bypass path toward the pop core
  input  logic                            bypass_ready,
  output logic                            bypass_valid,
  output fifo_pkg::fifo_item_t            bypass_item,

  // RAM write side
  output logic                            ram_wr_valid,
  output logic [fifo_pkg::FIFO_ADDR_W-1:0] ram_wr_addr,
  output fifo_pkg::fifo_item_t            ram_wr_item,

  // From occupancy tracker
  input  logic                            full
);

  import fifo_pkg::*;

  logic                   push_beat;
  logic [FIFO_ADDR_W-1:0] wr_addr_q;

  // ------------------------------
  // Flow control
  // ------------------------------

  // Ready only looks at the tracker, never at push_valid
  assign push_ready = !full;
  assign push_beat  = push_valid && push_ready;

  // ------------------------------
  // Write address
  // ------------------------------

  // Wraps at FIFO_DEPTH through natural overflow
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_addr_q <= '0;
    end else if (ram_wr_valid) begin
      wr_addr_q <= wr_addr_q + FIFO_ADDR_W'(1);
    end
  end

  assign ram_wr_addr = wr_addr_q;
  assign ram_wr_item = push_item;

  // ------------------------------
  // Bypass or RAM steering
  // ------------------------------

  if (EnableBypass) begin : gen_bypass
    // Offer every beat to the pop core
    assign bypass_valid = push_valid;
    assign bypass_item  = push_item;
    // RAM only takes what the pop core turned away
    assign ram_wr_valid = push_beat && !bypass_ready;
  end else begin : gen_no_bypass
    // Bypass outputs parked
    assign bypass_valid = 1'b0;
    assign bypass_item  = '0;
    // Every beat goes through the RAM
    assign ram_wr_valid = push_beat;
  end

  // No RAM write may land on a full array
  a_no_write_when_full : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ram_wr_valid && full)
  );

endmodule

//--- verilog/fifo_pop_ctrl_core.sv
// ------------------------------
// Pop control core with output stage,
// RAM read address and bypass intake
// ------------------------------

`timescale 1ns/1ps

module fifo_pop_ctrl_core #(
  parameter bit EnableBypass = 1'b1
) (
  input  logic                            clk,
  input  logic                            rst_n,

  // Bypass path from the push core
  input  logic                            bypass_valid,
  input  fifo_pkg::fifo_item_t            bypass_item,
  output logic                            bypass_ready,

  // RAM read side
  input  logic                            empty,
  output logic                            ram_rd_valid,
  output logic [fifo_pkg::FIFO_ADDR_W-1:0] ram_rd_addr,
  input  fifo_pkg::fifo_item_t            ram_rd_item,

  // Pop port
  input  logic                            pop_ready,
  output logic                            pop_valid,
  output fifo_pkg::fifo_item_t            pop_item
);

  import fifo_pkg::*;

  logic                   stage_valid_q;
  fifo_item_t             stage_item_q;
  logic [FIFO_ADDR_W-1:0] rd_addr_q;
  logic                   stage_free;
  logic                   bypass_beat;

  // ------------------------------
  // Stage availability
  // ------------------------------

  // Stage can take a new item when empty or being popped now
  assign stage_free = !stage_valid_q || pop_ready;

  // RAM read whenever something is stored and the stage has room
  assign ram_rd_valid = !empty && stage_free;

  if (EnableBypass) begin : gen_bypass
    // Bypass only when nothing older sits in the RAM
    assign bypass_ready = empty && stage_free;
    assign bypass_beat  = bypass_valid && bypass_ready;
  end else begin : gen_no_bypass
    // Path closed, all items come from the RAM
    assign bypass_ready = 1'b0;
    assign bypass_beat  = 1'b0;
  end

  // ------------------------------
  // Read address
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr_q <= '0;
    end else if (ram_rd_valid) begin
      rd_addr_q <= rd_addr_q + FIFO_ADDR_W'(1);
    end
  end

  assign ram_rd_addr = rd_addr_q;

  // ------------------------------
  // Output stage
  // ------------------------------

  // Valid flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid_q <= 1'b0;
    end else if (ram_rd_valid || bypass_beat) begin
      stage_valid_q <= 1'b1;
    end else if (pop_ready) begin
      // Popped with nothing behind it
      stage_valid_q <= 1'b0;
    end
  end

  // Data, RAM first so older items leave first
  always_ff @(posedge clk) begin
    if (ram_rd_valid) begin
      stage_item_q <= ram_rd_item;
    end else if (bypass_beat) begin
      stage_item_q <= bypass_item;
    end
  end

  assign pop_valid = stage_valid_q;
  assign pop_item  = stage_item_q;

  // Stalled beat keeps its data and its valid
  a_pop_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_item))
  );

endmodule

//--- verilog/fifo_occupancy.sv
// ------------------------------
// RAM item count with registered
// full and empty flags
// ------------------------------

`timescale 1ns/1ps

module fifo_occupancy (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             ram_wr_valid,
  input  logic                             ram_rd_valid,
  output logic                             full,
  output logic                             empty,
  output logic [fifo_pkg::FIFO_COUNT_W-1:0] ram_count
);

  import fifo_pkg::*;

  logic [FIFO_COUNT_W-1:0] count_q;
  logic [FIFO_COUNT_W-1:0] count_next;
  logic                    full_q;
  logic                    empty_q;

  // Next count
  // Write and read together cancel out
  always_comb begin
    unique case ({ram_wr_valid, ram_rd_valid})
      2'b10:   count_next = count_q + FIFO_COUNT_W'(1);
      2'b01:   count_next = count_q - FIFO_COUNT_W'(1);
      default: count_next = count_q;
    endcase
  end

  // Flags follow the next count so they match count_q every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      full_q  <= 1'b0;
      empty_q <= 1'b1;
    end else begin
      count_q <= count_next;
      full_q  <= (count_next == FIFO_COUNT_W'(FIFO_DEPTH));
      empty_q <= (count_next == '0);
    end
  end

  assign full      = full_q;
  assign empty     = empty_q;
  assign ram_count = count_q;

  // Count bounded by the array
  a_count_max : assert property (
    @(posedge clk) disable iff (!rst_n)
    ram_count <= FIFO_DEPTH
  );

  // Pop core never reads an empty RAM
  a_no_underflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    (ram_count == '0) |-> !ram_rd_valid
  );

endmodule

//--- verilog/fifo_flop_ram.sv
// ------------------------------
// Flop array storage, clocked write
// and combinational read
// ------------------------------

`timescale 1ns/1ps

module fifo_flop_ram (
  input  logic                            clk,

  // Write port
  input  logic                            wr_valid,
  input  logic [fifo_pkg::FIFO_ADDR_W-1:0] wr_addr,
  input  fifo_pkg::fifo_item_t            wr_item,

  // Read port
  input  logic [fifo_pkg::FIFO_ADDR_W-1:0] rd_addr,
  output fifo_pkg::fifo_item_t            rd_item
);

  import fifo_pkg::*;

  // ------------------------------
  // Storage
  // ------------------------------

  // Contents unknown until first written
  fifo_item_t mem_q [FIFO_DEPTH];

  // One entry per edge at most
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem_q[wr_addr] <= wr_item;
    end
  end

  // ------------------------------
  // Read
  // ------------------------------

  // Same-cycle read, stage captures it on the edge
  assign rd_item = mem_q[rd_addr];

endmodule

//--- verilog/fifo_ctrl_top.sv
// ------------------------------
// FIFO top, push and pop cores,
// occupancy tracker and flop RAM
// ------------------------------

`timescale 1ns/1ps

module fifo_ctrl_top (
  input  logic                             clk,
  input  logic                             rst_n,

  // Push port
  input  logic                             push_valid,
  input  fifo_pkg::fifo_item_t             push_item,
  output logic                             push_ready,

  // Pop port
  input  logic                             pop_ready,
  output logic                             pop_valid,
  output fifo_pkg::fifo_item_t             pop_item,

  // RAM occupancy, output stage not counted
  output logic [fifo_pkg::FIFO_COUNT_W-1:0] fifo_ram_count
);

  import fifo_pkg::*;

  // Bypass path
  logic                   bypass_valid;
  logic                   bypass_ready;
  fifo_item_t             bypass_item;

  // RAM write and read
  logic                   ram_wr_valid;
  logic [FIFO_ADDR_W-1:0] ram_wr_addr;
  fifo_item_t             ram_wr_item;
  logic                   ram_rd_valid;
  logic [FIFO_ADDR_W-1:0] ram_rd_addr;
  fifo_item_t             ram_rd_item;

  // Tracker flags
  logic                   full;
  logic                   empty;

  // ------------------------------
  // Push side
  // ------------------------------

  fifo_push_ctrl_core #(
    .EnableBypass(FIFO_ENABLE_BYPASS)
  ) u_push_ctrl (
    .clk,
    .rst_n,
    .push_valid,
    .push_item,
    .push_ready,
    .bypass_ready,
    .bypass_valid,
    .bypass_item,
    .ram_wr_valid,
    .ram_wr_addr,
    .ram_wr_item,
    .full
  );

  // ------------------------------
  // Pop side
  // ------------------------------

  fifo_pop_ctrl_core #(
    .EnableBypass(FIFO_ENABLE_BYPASS)
  ) u_pop_ctrl (
    .clk,
    .rst_n,
    .bypass_valid,
    .bypass_item,
    .bypass_ready,
    .empty,
    .ram_rd_valid,
    .ram_rd_addr,
    .ram_rd_item,
    .pop_ready,
    .pop_valid,
    .pop_item
  );

  // Occupancy of the RAM only
  fifo_occupancy u_occupancy (
    .clk,
    .rst_n,
    .ram_wr_valid,
    .ram_rd_valid,
    .full,
    .empty,
    .ram_count(fifo_ram_count)
  );

  // Storage
  fifo_flop_ram u_ram (
    .clk,
    .wr_valid(ram_wr_valid),
    .wr_addr (ram_wr_addr),
    .wr_item (ram_wr_item),
    .rd_addr (ram_rd_addr),
    .rd_item (ram_rd_item)
  );

endmodule

//--- testbench/fifo_ctrl_tb.sv
// ------------------------------
// Table-driven testbench for the FIFO
// with LFSR stimulus and queue model
// ------------------------------

`timescale 1ns/1ps

module fifo_ctrl_tb;

  import fifo_pkg::*;

  // One stimulus row
  // Push and pop classes are 0 for none, 1 for sparse, 2 for always
  // Mode is 0 for plain, 1 for the capacity check, 2 for the throughput check
  typedef struct packed {
    logic [7:0] cycles;
    logic [1:0] push_cls;
    logic [1:0] pop_cls;
    logic [1:0] mode;
  } stim_row_t;

  logic                    clk;
  logic                    rst_n;
  logic                    push_valid;
  fifo_item_t              push_item;
  logic                    push_ready;
  logic                    pop_ready;
  logic                    pop_valid;
  fifo_item_t              pop_item;
  logic [FIFO_COUNT_W-1:0] fifo_ram_count;

  // Model and generator state
  fifo_item_t  model_q [$];
  stim_row_t   stim_q [$];
  logic [31:0] lfsr_q;
  logic [15:0] seq_q;
  fifo_item_t  cur_item;
  logic        stall_q;
  fifo_item_t  stall_item_q;
  logic        bypass_pending;

  fifo_ctrl_top dut (
    .clk,
    .rst_n,
    .push_valid,
    .push_item,
    .push_ready,
    .pop_ready,
    .pop_valid,
    .pop_item,
    .fifo_ram_count
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------
  // Helpers
  // ------------------------------

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic rand_bit();
    lfsr_q = lfsr_step(lfsr_q);
    return lfsr_q[0];
  endfunction

  // Sparse fires about one cycle in four
  function automatic logic class_active(input logic [1:0] cls);
    logic b0;
    logic b1;
    if (cls == 2'd2) return 1'b1;
    if (cls != 2'd1) return 1'b0;
    b0 = rand_bit();
    b1 = rand_bit();
    return b0 & b1;
  endfunction

  // Sequence number payload, random tag
  function automatic fifo_item_t make_item();
    fifo_item_t it;
    for (int i = 0; i < FIFO_TAG_W; i++) begin
      it.tag[i] = rand_bit();
    end
    it.payload = seq_q;
    seq_q = seq_q + 16'd1;
    return it;
  endfunction

  task automatic report_failure(input string what);
    $display("error at %0t ns: %s", $time, what);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "value check on %s", name);
    end
  endtask

  task automatic add_row(input int cycles, input int push_cls, input int pop_cls, input int mode);
    stim_row_t r;
    r.cycles   = cycles[7:0];
    r.push_cls = push_cls[1:0];
    r.pop_cls  = pop_cls[1:0];
    r.mode     = mode[1:0];
    stim_q.push_back(r);
  endtask

  // ------------------------------
  // One clock cycle
  // ------------------------------

  // Drive on the rising edge, sample on the falling edge
  // Handshakes seen here complete on the following rising edge
  task automatic run_cycle(input logic [1:0] push_cls, input logic [1:0] pop_cls,
                           output logic push_fire, output logic pop_fire);
    logic       pv;
    logic       pr;
    logic       was_idle;
    fifo_item_t exp_item;
    pv = class_active(push_cls);
    pr = class_active(pop_cls);
    @(posedge clk);
    push_valid <= pv;
    push_item  <= cur_item;
    pop_ready  <= pr;
    @(negedge clk);
    // Stalled beat must not change
    if (stall_q) begin
      check_eq("pop_valid", pop_valid, 1);
      check_eq("pop_item", pop_item, stall_item_q);
    end
    // Bypass shows one cycle after the push, RAM untouched
    if (bypass_pending) begin
      check_eq("pop_valid", pop_valid, 1);
      check_eq("fifo_ram_count", fifo_ram_count, 0);
    end
    push_fire = push_valid && push_ready;
    pop_fire  = pop_valid && pop_ready;
    was_idle  = (model_q.size() == 0);
    if (pop_fire) begin
      if (model_q.size() == 0) report_failure("pop beat while no item was pending");
      exp_item = model_q.pop_front();
      check_eq("pop_item", pop_item, exp_item);
    end
    bypass_pending = push_fire && was_idle;
    if (push_fire) begin
      model_q.push_back(push_item);
      cur_item = make_item();
    end
    stall_q      = pop_valid && !pop_ready;
    stall_item_q = pop_item;
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    stim_row_t               row;
    logic                    pf;
    logic                    qf;
    int                      accepted;
    int                      drain_cycles;
    logic [FIFO_COUNT_W-1:0] start_count;
    rst_n          = 1'b0;
    push_valid     = 1'b0;
    push_item      = '0;
    pop_ready      = 1'b0;
    lfsr_q         = 32'd32425;
    seq_q          = 16'd0;
    stall_q        = 1'b0;
    stall_item_q   = '0;
    bypass_pending = 1'b0;
    start_count    = '0;
    cur_item       = make_item();

    // Cycles, push class, pop class, mode
    add_row(6, 0, 0, 0);
    add_row(8, 2, 0, 1);
    add_row(2, 0, 2, 0);
    add_row(12, 2, 2, 2);
    add_row(40, 1, 1, 0);
    add_row(40, 2, 1, 0);
    add_row(40, 1, 2, 0);
    add_row(30, 2, 2, 0);
    add_row(12, 0, 2, 0);
    add_row(30, 1, 0, 0);
    add_row(40, 2, 1, 0);

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq("pop_valid", pop_valid, 0);
    check_eq("push_ready", push_ready, 1);
    check_eq("fifo_ram_count", fifo_ram_count, 0);

    foreach (stim_q[i]) begin
      row      = stim_q[i];
      accepted = 0;
      // Capacity starts from nothing, throughput from a partly filled FIFO
      if (row.mode == 2'd1) check_eq("model_size", model_q.size(), 0);
      if (row.mode == 2'd2) begin
        check_eq("model_has_items", model_q.size() != 0, 1);
        // RAM holds everything except the staged item
        start_count = FIFO_COUNT_W'(model_q.size() - 1);
      end
      for (int c = 0; c < row.cycles; c++) begin
        run_cycle(row.push_cls, row.pop_cls, pf, qf);
        if (pf) accepted++;
        if (row.mode == 2'd2) begin
          check_eq("push_fire", pf, 1);
          check_eq("pop_fire", qf, 1);
          check_eq("fifo_ram_count", fifo_ram_count, start_count);
        end
      end
      if (row.mode == 2'd1) begin
        check_eq("accepted_beats", accepted, FIFO_DEPTH + 1);
        check_eq("push_ready", push_ready, 0);
        check_eq("fifo_ram_count", fifo_ram_count, FIFO_DEPTH);
      end
    end

    // Pop-only drain
    drain_cycles = 0;
    while (model_q.size() != 0 && drain_cycles < 64) begin
      run_cycle(2'd0, 2'd2, pf, qf);
      drain_cycles++;
    end
    if (model_q.size() != 0) begin
      report_failure("timeout, the FIFO did not drain within 64 cycles");
    end else begin
      run_cycle(2'd0, 2'd2, pf, qf);
      check_eq("pop_valid", pop_valid, 0);
      check_eq("fifo_ram_count", fifo_ram_count, 0);
      $display("sim passed");
      $finish;
    end
  end

endmodule

//--- fifo_ctrl_top.f
verilog/fifo_pkg.sv
verilog/fifo_push_ctrl_core.sv
verilog/fifo_pop_ctrl_core.sv
verilog/fifo_occupancy.sv
verilog/fifo_flop_ram.sv
verilog/fifo_ctrl_top.sv
testbench/fifo_ctrl_tb.sv

//--- Bender.yml
# Flop-based FIFO with push and pop control cores

package:
  name: fifo_ctrl

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - verilog/fifo_pkg.sv
      - verilog/fifo_push_ctrl_core.sv
      - verilog/fifo_pop_ctrl_core.sv
      - verilog/fifo_occupancy.sv
      - verilog/fifo_flop_ram.sv
      - verilog/fifo_ctrl_top.sv

  # Testbench, top module fifo_ctrl_tb
  - target: simulation
    files:
      - testbench/fifo_ctrl_tb.sv
